// ==== design/rv64_mini.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv64_mini
	import rv_isa_pkg::*;
	import rv_core_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC   = '0,
	parameter int              DMEM_WORDS = 64
) (
	input  wire logic            clk,
	input  wire logic            rst,
	output logic      [XLEN-1:0] pc_out,
	input  wire logic [31:0]     inst,        // combinational from pc_out
	output logic                 retire_valid,
	output logic      [XLEN-1:0] retire_pc,
	output reg_idx_t             retire_rd,
	output logic      [XLEN-1:0] retire_data
);

	logic            redirect;
	logic [XLEN-1:0] redirect_pc;
	reg_idx_t        rs1, rs2;
	logic [XLEN-1:0] rs1_data, rs2_data;

	// decode/execute register
	logic            d_valid, d_src_a_pc, d_src_b_imm, d_jalr;
	logic            d_mem_read, d_mem_write, d_reg_write;
	logic [XLEN-1:0] d_pc, d_rs1_data, d_rs2_data, d_imm;
	reg_idx_t        d_rs1, d_rs2, d_rd;
	alu_op_e         d_alu_op;
	br_kind_e        d_br_kind;
	wb_sel_e         d_wb_sel;

	// execute/memory register
	logic            e_valid, e_reg_write, e_mem_read, e_mem_write;
	logic [XLEN-1:0] e_pc, e_alu_result, e_store_data;
	reg_idx_t        e_rd;
	wb_sel_e         e_wb_sel;

	logic            wb_en;
	reg_idx_t        wb_rd;
	logic [XLEN-1:0] wb_data;

	rv_fetch #(.RESET_PC(RESET_PC)) fetch_inst (
		.clk(clk), .rst(rst), .redirect(redirect), .redirect_pc(redirect_pc),
		.f_pc(pc_out)
	);

	rv_decode decode_inst (
		.clk(clk), .rst(rst), .f_pc(pc_out), .inst(inst), .redirect(redirect),
		.rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.d_valid(d_valid), .d_pc(d_pc), .d_rs1(d_rs1), .d_rs2(d_rs2),
		.d_rs1_data(d_rs1_data), .d_rs2_data(d_rs2_data), .d_imm(d_imm), .d_rd(d_rd),
		.d_alu_op(d_alu_op), .d_src_a_pc(d_src_a_pc), .d_src_b_imm(d_src_b_imm),
		.d_br_kind(d_br_kind), .d_jalr(d_jalr), .d_mem_read(d_mem_read),
		.d_mem_write(d_mem_write), .d_wb_sel(d_wb_sel), .d_reg_write(d_reg_write)
	);

	rv_regfile regfile_inst (
		.clk(clk), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	rv_execute execute_inst (
		.clk(clk), .rst(rst),
		.d_valid(d_valid), .d_pc(d_pc), .d_rs1(d_rs1), .d_rs2(d_rs2),
		.d_rs1_data(d_rs1_data), .d_rs2_data(d_rs2_data), .d_imm(d_imm), .d_rd(d_rd),
		.d_alu_op(d_alu_op), .d_src_a_pc(d_src_a_pc), .d_src_b_imm(d_src_b_imm),
		.d_br_kind(d_br_kind), .d_jalr(d_jalr), .d_mem_read(d_mem_read),
		.d_mem_write(d_mem_write), .d_wb_sel(d_wb_sel), .d_reg_write(d_reg_write),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.e_valid(e_valid), .e_pc(e_pc), .e_rd(e_rd), .e_reg_write(e_reg_write),
		.e_wb_sel(e_wb_sel), .e_mem_read(e_mem_read), .e_mem_write(e_mem_write),
		.e_alu_result(e_alu_result), .e_store_data(e_store_data)
	);

	rv_memwb #(.DMEM_WORDS(DMEM_WORDS)) memwb_inst (
		.clk(clk), .rst(rst),
		.e_valid(e_valid), .e_pc(e_pc), .e_rd(e_rd), .e_reg_write(e_reg_write),
		.e_wb_sel(e_wb_sel), .e_mem_read(e_mem_read), .e_mem_write(e_mem_write),
		.e_alu_result(e_alu_result), .e_store_data(e_store_data),
		.wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
		.retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

endmodule

`default_nettype wire

// ==== design/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

	localparam int XLEN = 64;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // LUI, result is operand b
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK // pc + 4
	} wb_sel_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU,
		BR_JUMP // JAL and JALR, always taken
	} br_kind_e;

endpackage

`default_nettype wire

// ==== design/rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode
	import rv_isa_pkg::*;
	import rv_core_pkg::*;
(
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic [XLEN-1:0] f_pc,
	input  wire logic [31:0]     inst,
	input  wire logic            redirect,
	output reg_idx_t             rs1,
	output reg_idx_t             rs2,
	input  wire logic [XLEN-1:0] rs1_data,
	input  wire logic [XLEN-1:0] rs2_data,
	output logic                 d_valid,
	output logic      [XLEN-1:0] d_pc,
	output reg_idx_t             d_rs1,
	output reg_idx_t             d_rs2,
	output logic      [XLEN-1:0] d_rs1_data,
	output logic      [XLEN-1:0] d_rs2_data,
	output logic      [XLEN-1:0] d_imm,
	output reg_idx_t             d_rd,
	output alu_op_e              d_alu_op,
	output logic                 d_src_a_pc,
	output logic                 d_src_b_imm,
	output br_kind_e             d_br_kind,
	output logic                 d_jalr,
	output logic                 d_mem_read,
	output logic                 d_mem_write,
	output wb_sel_e              d_wb_sel,
	output logic                 d_reg_write
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [XLEN-1:0] imm;
	alu_op_e         alu_op;
	br_kind_e        br_kind;
	wb_sel_e         wb_sel;
	logic            src_a_pc, src_b_imm, jalr, mem_read, mem_write, reg_write;

	// one alu function per funct3, alt bits only matter for ADD and SR
	function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic sub, input logic sra);
		case (f3)
			F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return sra ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_e'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		imm       = imm_i;
		alu_op    = ALU_ADD;
		br_kind   = BR_NONE;
		wb_sel    = WB_ALU;
		src_a_pc  = 1'b0;
		src_b_imm = 1'b0;
		jalr      = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0; // unknown opcodes fall through as a no-op
		case (opcode)
			OPC_LUI: begin
				imm       = imm_u;
				alu_op    = ALU_PASS_B;
				src_b_imm = 1'b1;
				reg_write = 1'b1;
			end
			OPC_AUIPC: begin
				imm       = imm_u;
				src_a_pc  = 1'b1;
				src_b_imm = 1'b1;
				reg_write = 1'b1;
			end
			OPC_JAL: begin
				imm       = imm_j;
				br_kind   = BR_JUMP;
				wb_sel    = WB_LINK;
				reg_write = 1'b1;
			end
			OPC_JALR: begin
				br_kind   = BR_JUMP;
				jalr      = 1'b1;
				wb_sel    = WB_LINK;
				reg_write = 1'b1;
			end
			OPC_BRANCH: begin
				imm = imm_b;
				case (funct3)
					F3_BEQ:  br_kind = BR_EQ;
					F3_BNE:  br_kind = BR_NE;
					F3_BLT:  br_kind = BR_LT;
					F3_BGE:  br_kind = BR_GE;
					F3_BLTU: br_kind = BR_LTU;
					F3_BGEU: br_kind = BR_GEU;
					default: br_kind = BR_NONE;
				endcase
			end
			OPC_LOAD: begin
				src_b_imm = 1'b1;
				wb_sel    = WB_MEM;
				mem_read  = (funct3 == F3_DOUBLE); // only LD
				reg_write = (funct3 == F3_DOUBLE);
			end
			OPC_STORE: begin
				imm       = imm_s;
				src_b_imm = 1'b1;
				mem_write = (funct3 == F3_DOUBLE); // only SD
			end
			OPC_OP_IMM: begin
				src_b_imm = 1'b1;
				reg_write = 1'b1;
				// inst[25] is shamt[5] in RV64, so only funct6 tells SRAI apart
				alu_op    = f3_to_alu(funct3, 1'b0, funct7[6:1] == F7_ALT[6:1]);
			end
			OPC_OP: begin
				reg_write = 1'b1;
				alu_op    = f3_to_alu(funct3, funct7 == F7_ALT, funct7 == F7_ALT);
			end
			default: ;
		endcase
	end

	// control bits, cleared on reset and squashed to a bubble on redirect
	always_ff @(posedge clk) begin
		if (rst || redirect) begin
			d_valid     <= 1'b0;
			d_br_kind   <= BR_NONE;
			d_mem_read  <= 1'b0;
			d_mem_write <= 1'b0;
			d_reg_write <= 1'b0;
		end else begin
			d_valid     <= 1'b1;
			d_br_kind   <= br_kind;
			d_mem_read  <= mem_read;
			d_mem_write <= mem_write;
			d_reg_write <= reg_write;
		end
	end

	always_ff @(posedge clk) begin
		d_pc        <= f_pc;
		d_rs1       <= rs1;
		d_rs2       <= rs2;
		d_rs1_data  <= rs1_data;
		d_rs2_data  <= rs2_data;
		d_imm       <= imm;
		d_rd        <= inst[11:7];
		d_alu_op    <= alu_op;
		d_src_a_pc  <= src_a_pc;
		d_src_b_imm <= src_b_imm;
		d_jalr      <= jalr;
		d_wb_sel    <= wb_sel;
	end

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute
	import rv_isa_pkg::*;
	import rv_core_pkg::*;
(
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            d_valid,
	input  wire logic [XLEN-1:0] d_pc,
	input  wire reg_idx_t        d_rs1,
	input  wire reg_idx_t        d_rs2,
	input  wire logic [XLEN-1:0] d_rs1_data,
	input  wire logic [XLEN-1:0] d_rs2_data,
	input  wire logic [XLEN-1:0] d_imm,
	input  wire reg_idx_t        d_rd,
	input  wire alu_op_e         d_alu_op,
	input  wire logic            d_src_a_pc,
	input  wire logic            d_src_b_imm,
	input  wire br_kind_e        d_br_kind,
	input  wire logic            d_jalr,
	input  wire logic            d_mem_read,
	input  wire logic            d_mem_write,
	input  wire wb_sel_e         d_wb_sel,
	input  wire logic            d_reg_write,
	input  wire logic            wb_en,
	input  wire reg_idx_t        wb_rd,
	input  wire logic [XLEN-1:0] wb_data,
	output logic                 redirect,
	output logic      [XLEN-1:0] redirect_pc,
	output logic                 e_valid,
	output logic      [XLEN-1:0] e_pc,
	output reg_idx_t             e_rd,
	output logic                 e_reg_write,
	output wb_sel_e              e_wb_sel,
	output logic                 e_mem_read,
	output logic                 e_mem_write,
	output logic      [XLEN-1:0] e_alu_result,
	output logic      [XLEN-1:0] e_store_data
);

	logic [XLEN-1:0] rs1_val, rs2_val;
	logic [XLEN-1:0] alu_a, alu_b, alu_y;
	logic [5:0]      shamt;
	logic            eq, lt, ltu, taken;

	// the previous instruction is in writeback now, older ones come via the regfile
	assign rs1_val = (wb_en && wb_rd != 5'd0 && wb_rd == d_rs1) ? wb_data : d_rs1_data;
	assign rs2_val = (wb_en && wb_rd != 5'd0 && wb_rd == d_rs2) ? wb_data : d_rs2_data;

	assign alu_a = d_src_a_pc ? d_pc : rs1_val;
	assign alu_b = d_src_b_imm ? d_imm : rs2_val;
	assign shamt = alu_b[5:0];

	always_comb begin
		case (d_alu_op)
			ALU_ADD:    alu_y = alu_a + alu_b;
			ALU_SUB:    alu_y = alu_a - alu_b;
			ALU_SLL:    alu_y = alu_a << shamt;
			ALU_SLT:    alu_y = {63'd0, $signed(alu_a) < $signed(alu_b)};
			ALU_SLTU:   alu_y = {63'd0, alu_a < alu_b};
			ALU_XOR:    alu_y = alu_a ^ alu_b;
			ALU_SRL:    alu_y = alu_a >> shamt;
			ALU_SRA:    alu_y = $signed(alu_a) >>> shamt;
			ALU_OR:     alu_y = alu_a | alu_b;
			ALU_AND:    alu_y = alu_a & alu_b;
			ALU_PASS_B: alu_y = alu_b;
			default:    alu_y = '0;
		endcase
	end

	// branch compare always works on the register operands
	assign eq  = (rs1_val == rs2_val);
	assign lt  = ($signed(rs1_val) < $signed(rs2_val));
	assign ltu = (rs1_val < rs2_val);

	always_comb begin
		case (d_br_kind)
			BR_EQ:   taken = eq;
			BR_NE:   taken = !eq;
			BR_LT:   taken = lt;
			BR_GE:   taken = !lt;
			BR_LTU:  taken = ltu;
			BR_GEU:  taken = !ltu;
			BR_JUMP: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign redirect = d_valid && taken;

	always_comb begin
		if (d_jalr) begin
			redirect_pc = (rs1_val + d_imm) & ~64'd1;
		end else begin
			redirect_pc = d_pc + d_imm;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			e_valid     <= 1'b0;
			e_reg_write <= 1'b0;
			e_mem_read  <= 1'b0;
			e_mem_write <= 1'b0;
		end else begin
			e_valid     <= d_valid;
			e_reg_write <= d_valid && d_reg_write;
			e_mem_read  <= d_valid && d_mem_read;
			e_mem_write <= d_valid && d_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		e_pc         <= d_pc;
		e_rd         <= d_rd;
		e_wb_sel     <= d_wb_sel;
		e_alu_result <= alu_y;   // also the load/store address
		e_store_data <= rs2_val;
	end

endmodule

`default_nettype wire

// ==== design/rv_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_fetch
	import rv_core_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            redirect,
	input  wire logic [XLEN-1:0] redirect_pc,
	output logic      [XLEN-1:0] f_pc
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] next_pc;

	// taken branch or jump from execute wins over the sequential pc
	always_comb begin
		if (redirect) begin
			next_pc = redirect_pc;
		end else begin
			next_pc = pc + 64'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

	assign f_pc = pc; // goes straight out as pc_out

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	// major opcodes of the supported RV64I subset
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// alu functions, shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA, picked by funct7
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [2:0] F3_DOUBLE = 3'b011; // LD / SD width

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA

	typedef logic [4:0] reg_idx_t;

endpackage

`default_nettype wire

// ==== design/rv_memwb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_memwb
	import rv_isa_pkg::*;
	import rv_core_pkg::*;
#(
	parameter int DMEM_WORDS = 64
) (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            e_valid,
	input  wire logic [XLEN-1:0] e_pc,
	input  wire reg_idx_t        e_rd,
	input  wire logic            e_reg_write,
	input  wire wb_sel_e         e_wb_sel,
	input  wire logic            e_mem_read,
	input  wire logic            e_mem_write,
	input  wire logic [XLEN-1:0] e_alu_result,
	input  wire logic [XLEN-1:0] e_store_data,
	output logic                 wb_en,
	output reg_idx_t             wb_rd,
	output logic      [XLEN-1:0] wb_data,
	output logic                 retire_valid,
	output logic      [XLEN-1:0] retire_pc,
	output reg_idx_t             retire_rd,
	output logic      [XLEN-1:0] retire_data
);

	localparam int IDX_W = $clog2(DMEM_WORDS);

	logic [XLEN-1:0]  dmem [DMEM_WORDS];
	logic [IDX_W-1:0] mem_idx;
	logic [XLEN-1:0]  load_data;
	logic [XLEN-1:0]  wb_value;

	assign mem_idx = e_alu_result[IDX_W+2:3]; // doubleword index, upper bits wrap

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (e_valid && e_mem_write) begin
			dmem[mem_idx] <= e_store_data;
		end
	end

	assign load_data = e_mem_read ? dmem[mem_idx] : '0;

	always_comb begin
		case (e_wb_sel)
			WB_MEM:  wb_value = load_data;
			WB_LINK: wb_value = e_pc + 64'd4;
			default: wb_value = e_alu_result;
		endcase
	end

	// a write to x0 counts as no write at all
	assign wb_en   = e_valid && e_reg_write && e_rd != 5'd0;
	assign wb_rd   = e_rd;
	assign wb_data = wb_value;

	assign retire_valid = e_valid;
	assign retire_pc    = e_pc;
	assign retire_rd    = wb_en ? e_rd : 5'd0;
	assign retire_data  = wb_en ? wb_value : '0;

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile
	import rv_isa_pkg::*;
(
	input  wire logic        clk,
	input  wire reg_idx_t    rs1,
	input  wire reg_idx_t    rs2,
	output logic      [63:0] rs1_data,
	output logic      [63:0] rs2_data,
	input  wire logic        wb_en,
	input  wire reg_idx_t    wb_rd,
	input  wire logic [63:0] wb_data
);

	logic [63:0] regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (wb_en && wb_rd != 5'd0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// same-cycle writeback is visible to decode
	assign rs1_data = (rs1 == 5'd0) ? 64'd0 :
		(wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? 64'd0 :
		(wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

`default_nettype wire

// ==== rv64_mini.f ====
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_memwb.sv
design/rv64_mini.sv
testbench/rv64_mini_chk.sv
testbench/rv64_mini_tb.sv

// ==== testbench/rv64_mini_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv64_mini_chk (
	input wire logic        clk,
	input wire logic        rst,
	input wire logic [63:0] pc_out,
	input wire logic        retire_valid,
	input wire logic [4:0]  retire_rd,
	input wire logic [63:0] retire_data
);

	// fetch addresses stay word aligned once the core runs
	assert property (@(posedge clk) disable iff (rst) pc_out[1:0] == 2'b00)
		else $error("pc_out is not a multiple of 4");

	// nothing written means nothing reported
	assert property (@(posedge clk) disable iff (rst)
		(retire_valid && retire_rd == 5'd0) |-> retire_data == 64'd0)
		else $error("retire_data is nonzero while retire_rd is zero");

	assert property (@(posedge clk) disable iff (rst) !$isunknown(retire_valid))
		else $error("retire_valid is unknown after reset");

endmodule

`default_nettype wire

// ==== testbench/rv64_mini_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv64_mini_tb
	import rv_isa_pkg::*;
;

	localparam logic [63:0] RESET_PC    = 64'd0;
	localparam int          DMEM_WORDS  = 64;
	localparam int          PROG_MAX    = 512;
	localparam int          MODEL_STEPS = 2000;
	localparam logic [31:0] SELF_LOOP   = 32'h0000006f; // JAL x0, 0
	localparam int unsigned SEED        = 32'h1c019580;

	localparam logic [2:0] BR_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
	localparam logic [2:0] R_F3 [10] = '{F3_ADD, F3_ADD, F3_SLL, F3_SLT, F3_SLTU,
		F3_XOR, F3_SR, F3_SR, F3_OR, F3_AND};
	localparam logic [9:0] R_ALT = 10'b0010000010; // SUB and SRA

	logic        clk;
	logic        rst;
	logic [63:0] pc_out;
	logic [31:0] inst;
	logic        retire_valid;
	logic [63:0] retire_pc;
	reg_idx_t    retire_rd;
	logic [63:0] retire_data;

	logic [31:0] prog [PROG_MAX];
	int          prog_len = 0;
	logic [63:0] mregs [32];         // reference model state
	logic [63:0] mmem [DMEM_WORDS];
	logic [63:0] exp_pc [$];
	reg_idx_t    exp_rd [$];
	logic [63:0] exp_data [$];

	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;

	rv64_mini rv64_mini_inst (
		.clk(clk), .rst(rst), .pc_out(pc_out), .inst(inst),
		.retire_valid(retire_valid), .retire_pc(retire_pc),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	bind rv64_mini rv64_mini_chk rv64_mini_chk_inst (
		.clk(clk), .rst(rst), .pc_out(pc_out), .retire_valid(retire_valid),
		.retire_rd(retire_rd), .retire_data(retire_data)
	);

	// instruction memory, past the program end the core spins in place
	assign inst = (pc_out[63:2] < 62'(prog_len)) ? prog[pc_out[10:2]] : SELF_LOOP;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: retire stream stalled after %0d cycles", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] r_type(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1);
		return {imm[11:5], rs2, rs1, F3_DOUBLE, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input reg_idx_t rs1,
		input reg_idx_t rs2, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input reg_idx_t rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	// hold the core in reset and load a preamble that gives every register a value
	task automatic start_program();
		rst = 1'b1;
		prog_len = 0;
		for (int r = 1; r < 32; r++) begin
			emit(i_type(12'($urandom), 5'd0, F3_ADD, 5'(r), OPC_OP_IMM));
		end
	endtask

	function automatic logic [31:0] fetch_word(input logic [63:0] addr);
		if (addr[63:2] < 62'(prog_len)) begin
			return prog[addr[10:2]];
		end
		return SELF_LOOP;
	endfunction

	function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [63:0] a, input logic [63:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[5:0];
			3'd2: return {63'd0, $signed(a) < $signed(b)};
			3'd3: return {63'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [63:0] a,
		input logic [63:0] b);
		case (f3)
			F3_BEQ:  return a == b;
			F3_BNE:  return a != b;
			F3_BLT:  return $signed(a) < $signed(b);
			F3_BGE:  return $signed(a) >= $signed(b);
			F3_BLTU: return a < b;
			F3_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	function automatic int mem_index(input logic [63:0] addr);
		return int'((addr >> 3) % DMEM_WORDS); // wraps modulo the depth
	endfunction

	task automatic record(input logic [63:0] pc, input reg_idx_t rd, input logic [63:0] data);
		exp_pc.push_back(pc);
		exp_rd.push_back(rd);
		exp_data.push_back(data);
	endtask

	// ISA-level execution of the loaded program up to the self-loop
	task automatic run_model();
		logic [63:0] pc, nxt, a, b, val, imm_i, imm_s, imm_b, imm_u, imm_j;
		logic [31:0] w;
		reg_idx_t    rd;
		logic        wr;
		int          steps;
		pc = RESET_PC;
		steps = 0;
		exp_pc.delete();
		exp_rd.delete();
		exp_data.delete();
		for (int i = 0; i < 32; i++) mregs[i] = 64'd0;
		for (int i = 0; i < DMEM_WORDS; i++) mmem[i] = 64'd0;
		while (1) begin
			w = fetch_word(pc);
			if (w == SELF_LOOP) begin
				record(pc, 5'd0, 64'd0); // the loop itself retires once before the stop
				break;
			end
			a = mregs[w[19:15]];
			b = mregs[w[24:20]];
			rd = w[11:7];
			imm_i = {{52{w[31]}}, w[31:20]};
			imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			imm_u = {{32{w[31]}}, w[31:12], 12'd0};
			imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			wr = 1'b1;
			val = 64'd0;
			nxt = pc + 64'd4;
			case (w[6:0])
				OPC_LUI:    val = imm_u;
				OPC_AUIPC:  val = pc + imm_u;
				OPC_JAL: begin
					val = pc + 64'd4;
					nxt = pc + imm_j;
				end
				OPC_JALR: begin
					val = pc + 64'd4;
					nxt = (a + imm_i) & ~64'd1;
				end
				OPC_BRANCH: begin
					wr = 1'b0;
					if (branch_taken(w[14:12], a, b)) nxt = pc + imm_b;
				end
				OPC_LOAD:   val = mmem[mem_index(a + imm_i)];
				OPC_STORE: begin
					wr = 1'b0;
					mmem[mem_index(a + imm_s)] = b;
				end
				OPC_OP_IMM: val = alu_ref(w[14:12], w[14:12] == F3_SR && w[30], a, imm_i);
				OPC_OP:     val = alu_ref(w[14:12], w[30], a, b);
				default:    wr = 1'b0;
			endcase
			if (wr && rd != 5'd0) begin
				mregs[rd] = val;
				record(pc, rd, val);
			end else begin
				record(pc, 5'd0, 64'd0);
			end
			pc = nxt;
			steps++;
			if (steps > MODEL_STEPS) begin
				$display("reference model did not reach the self-loop in %0d steps", steps);
				errors++;
				break;
			end
		end
	endtask

	// called on a falling edge with rst already high
	task automatic apply_reset();
		repeat (3) begin
			@(posedge clk);
			@(negedge clk);
			assert (pc_out === RESET_PC) else begin
				$display("mismatch pc_out in reset: got %h expected %h", pc_out, RESET_PC);
				errors++;
			end
			assert (retire_valid === 1'b0) else begin
				$display("mismatch retire_valid in reset: got %h expected 0", retire_valid);
				errors++;
			end
		end
		rst = 1'b0;
		@(posedge clk);
		@(negedge clk);
		assert (retire_valid === 1'b0) else begin
			$display("mismatch retire_valid after reset: got %h expected 0", retire_valid);
			errors++;
		end
	endtask

	task automatic check_retire(input int idx);
		assert (retire_pc === exp_pc[idx]) else begin
			$display("mismatch retire_pc #%0d: got %h expected %h", idx, retire_pc, exp_pc[idx]);
			errors++;
		end
		assert (retire_rd === exp_rd[idx]) else begin
			$display("mismatch retire_rd #%0d: got %h expected %h", idx, retire_rd, exp_rd[idx]);
			errors++;
		end
		assert (retire_data === exp_data[idx]) else begin
			$display("mismatch retire_data #%0d: got %h expected %h", idx, retire_data,
				exp_data[idx]);
			errors++;
		end
	endtask

	task automatic run_test(input string name);
		int n;
		int idx;
		int errs_before;
		errs_before = errors;
		run_model();
		n = exp_pc.size();
		cycle_limit += 2 * n + 50; // at most one bubble per instruction
		apply_reset();
		idx = 0;
		while (idx < n && errors == errs_before) begin // stop at the first bad event
			@(negedge clk);
			if (retire_valid === 1'b1) begin
				check_retire(idx);
				idx++;
			end
		end
		tests_run++;
		if (errors != errs_before) tests_failed++;
		$display("test %s: %0d retires expected, %0d checked, %0d errors", name, n, idx,
			errors - errs_before);
	endtask

	task automatic arith_test();
		start_program();
		emit(u_type(20'h80001, 5'd1, OPC_LUI));
		emit(i_type(12'hffb, 5'd1, F3_ADD, 5'd2, OPC_OP_IMM));
		emit(i_type(12'd7, 5'd2, F3_SLT, 5'd3, OPC_OP_IMM));
		emit(i_type(12'd1, 5'd3, F3_SLTU, 5'd4, OPC_OP_IMM));
		emit(i_type(12'h5a5, 5'd4, F3_XOR, 5'd5, OPC_OP_IMM));
		emit(i_type(12'h0f0, 5'd5, F3_OR, 5'd6, OPC_OP_IMM));
		emit(i_type(12'h03c, 5'd6, F3_AND, 5'd7, OPC_OP_IMM));
		emit(i_type(12'd35, 5'd1, F3_SLL, 5'd8, OPC_OP_IMM)); // shamt above 31
		emit(i_type(12'd33, 5'd8, F3_SR, 5'd9, OPC_OP_IMM));
		emit(i_type(12'h428, 5'd8, F3_SR, 5'd10, OPC_OP_IMM)); // SRAI by 40
		// each register op takes the previous result as rs1
		for (int k = 0; k < 10; k++) begin
			emit(r_type(R_ALT[k] ? F7_ALT : F7_BASE, 5'(k + 1), 5'(k + 10), R_F3[k], 5'(k + 11)));
		end
		emit(r_type(F7_BASE, 5'd19, 5'd20, F3_ADD, 5'd0));
		emit(i_type(12'h7ff, 5'd0, F3_ADD, 5'd21, OPC_OP_IMM));
		emit(r_type(F7_BASE, 5'd20, 5'd0, F3_OR, 5'd22));
		run_test("arith");
	endtask

	task automatic memory_test();
		start_program();
		emit(s_type(12'd8, 5'd2, 5'd0));
		emit(i_type(12'd8, 5'd0, F3_DOUBLE, 5'd3, OPC_LOAD));  // right behind the store
		emit(i_type(12'd1, 5'd3, F3_ADD, 5'd4, OPC_OP_IMM));   // load result used at once
		emit(s_type(12'd16, 5'd4, 5'd0));
		emit(s_type(12'd528, 5'd5, 5'd0));                     // aliases address 16
		emit(i_type(12'd16, 5'd0, F3_DOUBLE, 5'd6, OPC_LOAD));
		emit(i_type(12'd40, 5'd0, F3_ADD, 5'd7, OPC_OP_IMM));
		emit(s_type(12'd8, 5'd6, 5'd7));
		emit(i_type(12'd8, 5'd7, F3_DOUBLE, 5'd8, OPC_LOAD));
		emit(i_type(12'hfe8, 5'd7, F3_DOUBLE, 5'd9, OPC_LOAD));
		emit(r_type(F7_BASE, 5'd9, 5'd8, F3_ADD, 5'd10));
		run_test("memory");
	endtask

	task automatic branch_skip(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2);
		emit(b_type(13'd8, rs1, rs2, f3));
		emit(i_type(12'd1, 5'd3, F3_ADD, 5'd3, OPC_OP_IMM)); // skipped when taken
	endtask

	task automatic control_test();
		start_program();
		emit(i_type(12'd5, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM));
		emit(i_type(12'hffd, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM)); // x2 = -3
		branch_skip(F3_BEQ, 5'd1, 5'd1);
		branch_skip(F3_BEQ, 5'd1, 5'd2);
		branch_skip(F3_BNE, 5'd1, 5'd2);
		branch_skip(F3_BNE, 5'd1, 5'd1);
		branch_skip(F3_BLT, 5'd2, 5'd1);
		branch_skip(F3_BLT, 5'd1, 5'd2);
		branch_skip(F3_BGE, 5'd1, 5'd2);
		branch_skip(F3_BGE, 5'd2, 5'd1);
		branch_skip(F3_BLTU, 5'd1, 5'd2);
		branch_skip(F3_BLTU, 5'd2, 5'd1);
		branch_skip(F3_BGEU, 5'd2, 5'd1);
		branch_skip(F3_BGEU, 5'd1, 5'd2);
		emit(j_type(21'd8, 5'd5));
		emit(i_type(12'd1, 5'd3, F3_ADD, 5'd3, OPC_OP_IMM));
		emit(u_type(20'd0, 5'd6, OPC_AUIPC));
		emit(i_type(12'd17, 5'd6, 3'b000, 5'd7, OPC_JALR)); // odd target, lands 16 past AUIPC
		emit(i_type(12'd1, 5'd3, F3_ADD, 5'd3, OPC_OP_IMM));
		emit(i_type(12'd1, 5'd3, F3_ADD, 5'd3, OPC_OP_IMM));
		emit(r_type(F7_BASE, 5'd7, 5'd5, F3_ADD, 5'd8));
		run_test("control");
	endtask

	task automatic random_test();
		reg_idx_t    rd, rs1, rs2;
		logic [2:0]  f3;
		logic [11:0] imm;
		int          sel;
		start_program();
		for (int i = 0; i < 200; i++) begin
			rd = 5'($urandom);
			rs1 = 5'($urandom);
			rs2 = 5'($urandom);
			f3 = 3'($urandom);
			imm = 12'($urandom);
			sel = int'($urandom % 9);
			case (sel)
				0: emit(u_type(20'($urandom), rd, OPC_LUI));
				1: emit(u_type(20'($urandom), rd, OPC_AUIPC));
				2: begin
					if (f3 == F3_SLL) imm = {6'd0, imm[5:0]};
					else if (f3 == F3_SR) imm = {1'b0, imm[10], 4'd0, imm[5:0]};
					emit(i_type(imm, rs1, f3, rd, OPC_OP_IMM));
				end
				3: emit(r_type(((f3 == F3_ADD || f3 == F3_SR) && $urandom % 2 == 1) ?
					F7_ALT : F7_BASE, rs2, rs1, f3, rd));
				4: emit(i_type(12'(($urandom % DMEM_WORDS) * 8), 5'd0, F3_DOUBLE, rd, OPC_LOAD));
				5: emit(s_type(12'(($urandom % DMEM_WORDS) * 8), rs2, 5'd0));
				6: emit(b_type(13'(4 * (1 + $urandom % 8)), rs1, rs2, BR_F3[$urandom % 6]));
				7: emit(j_type(21'(4 * (1 + $urandom % 8)), rd));
				default: emit(i_type(12'(prog_len * 4 + 4 * (1 + $urandom % 8) + $urandom % 2),
					5'd0, 3'b000, rd, OPC_JALR)); // absolute forward target
			endcase
		end
		run_test("random");
	endtask

	initial begin
		rst = 1'b1;
		void'($urandom(SEED));
		arith_test();
		memory_test();
		control_test();
		random_test();
		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
